// ==== flist.f ====
+incdir+.
tmu_pkg.sv
tmu_ctlif.sv
tmu_clip.sv
tmu_decay.sv
tmu_burst.sv
tmu_top.sv
tmu_assert.sv
tb_tmu.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_tmu -f flist.f || exit 1
out=$(./obj_dir/Vtb_tmu +verilator+error+limit+100 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Regression passed" && exit 0 || exit 1

// ==== tb_tmu.sv ====
/* testbench for the texture mapping pixel back end
   reference point model, burst model and burst compare process */
`timescale 1ns/1ns
`include "tmu_consts.svh"

module tb_tmu;

	localparam int N_A = 64;
	localparam int N_B = 40;
	localparam int N_C = 80;
	localparam int LIMIT = 4 * (N_A + N_B + N_C) + 2000; // cycles

	logic sys_clk, sys_rst;
	tmu_pkg::csr_adr_t csr_a_i;
	logic csr_we_i;
	logic [31:0] csr_di_i, csr_do_o;
	logic irq_o, pt_stb_i, pt_ack_o, pt_last_i, burst_stb_o, burst_ack_i;
	tmu_pkg::coord_t pt_x_i, pt_y_i;
	tmu_pkg::pixel_t pt_color_i;
	tmu_pkg::burst_adr_t burst_adr_o;
	tmu_pkg::burst_sel_t burst_sel_o;
	tmu_pkg::burst_data_t burst_dat_o;

	integer seed = 32'h5ef2a99a;
	bit stall_on = 1'b0;
	int model_cnt = 0;
	int seen_cnt = 0;
	int irq_cnt = 0;
	int frames = 0;
	int cycles = 0;

	tmu_pkg::bright_t cfg_bright; // settings as written to the CSRs
	bit cfg_ken;
	tmu_pkg::pixel_t cfg_key;
	tmu_pkg::dadr_t cfg_fbuf;
	tmu_pkg::res_t cfg_hres, cfg_vres;
	tmu_pkg::coord_t cfg_hoff, cfg_voff;

	tmu_pkg::burst_adr_t m_adr; // open burst of the model
	tmu_pkg::burst_sel_t m_sel;
	tmu_pkg::burst_data_t m_dat;
	tmu_pkg::burst_adr_t exp_adr_q[$];
	tmu_pkg::burst_sel_t exp_sel_q[$];
	tmu_pkg::burst_data_t exp_dat_q[$];

	tmu_top dut0 (.*);

	bind tmu_top tmu_assert assert0 (
		.sys_clk, .sys_rst, .burst_stb_i(burst_stb_o), .burst_ack_i,
		.burst_adr_i(burst_adr_o), .burst_sel_i(burst_sel_o),
		.burst_dat_i(burst_dat_o), .irq_i(irq_o)
	);

	always #10 sys_clk = ~sys_clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "simulation stopped");
	endtask

	// keep flag and word address plus output colour of one point
	function automatic bit ref_point(input tmu_pkg::coord_t x, input tmu_pkg::coord_t y,
		input tmu_pkg::pixel_t c, input tmu_pkg::coord_t ho, input tmu_pkg::coord_t vo,
		input tmu_pkg::res_t hr, input tmu_pkg::res_t vr, input tmu_pkg::dadr_t fb,
		input tmu_pkg::bright_t br, input bit ken, input tmu_pkg::pixel_t key,
		output tmu_pkg::dadr_t adr, output tmu_pkg::pixel_t col);
		int fx, fy, k, r, g, b;
		fx = int'(x) + int'(ho);
		fy = int'(y) + int'(vo);
		k = int'(br) + 1;
		r = (int'(c[15:11]) * k) >> 6;
		g = (int'(c[10:5]) * k) >> 6;
		b = (int'(c[4:0]) * k) >> 6;
		adr = tmu_pkg::dadr_t'(int'(fb) + fy * int'(hr) + fx);
		col = {5'(r), 6'(g), 5'(b)};
		if (ken && c == key)
			return 1'b0;
		return fx >= 0 && fx < int'(hr) && fy >= 0 && fy < int'(vr);
	endfunction

	task automatic push_open();
		exp_adr_q.push_back(m_adr);
		exp_sel_q.push_back(m_sel);
		exp_dat_q.push_back(m_dat);
		model_cnt++;
		m_sel = '0;
	endtask

	task automatic model_pixel(input tmu_pkg::dadr_t adr, input tmu_pkg::pixel_t col);
		tmu_pkg::burst_adr_t badr;
		int slot;
		badr = tmu_pkg::burst_adr_t'(adr >> 2);
		slot = int'(adr[1:0]);
		if (m_sel != '0 && badr != m_adr)
			push_open(); // pixel of another burst closes the open one
		m_adr = badr;
		m_sel[2*slot +: 2] = 2'b11;
		m_dat[16*slot +: 16] = col;
	endtask

	task automatic check_burst(input tmu_pkg::burst_adr_t ea, input tmu_pkg::burst_sel_t es,
		input tmu_pkg::burst_data_t ed);
		tmu_pkg::burst_data_t mask;
		for (int i = 0; i < 8; i++)
			mask[8*i +: 8] = {8{es[i]}}; // only selected bytes carry data
		if (burst_adr_o !== ea)
			abort_run($sformatf("error t=%0t burst_adr_o exp %h got %h", $time, ea, burst_adr_o));
		else if (burst_sel_o !== es)
			abort_run($sformatf("error t=%0t burst_sel_o exp %h got %h", $time, es, burst_sel_o));
		else if ((burst_dat_o & mask) !== (ed & mask))
			abort_run($sformatf("error t=%0t burst_dat_o exp %h got %h", $time,
				ed & mask, burst_dat_o & mask));
	endtask

	task automatic check_csr(input tmu_pkg::csr_adr_t a, input logic [31:0] exp_val);
		@(negedge sys_clk);
		csr_a_i = a;
		@(negedge sys_clk);
		if (csr_do_o !== exp_val)
			abort_run($sformatf("error t=%0t csr_do_o[%0d] exp %h got %h", $time, a,
				exp_val, csr_do_o));
	endtask

	task automatic check_count(input string what, input int exp_val, input int got);
		if (got != exp_val)
			abort_run($sformatf("error t=%0t %s exp %0d got %0d", $time, what, exp_val, got));
	endtask

	task automatic csr_write(input tmu_pkg::csr_adr_t a, input logic [31:0] d);
		@(negedge sys_clk);
		csr_a_i = a;
		csr_we_i = 1'b1;
		csr_di_i = d;
		@(negedge sys_clk);
		csr_we_i = 1'b0;
	endtask

	task automatic write_config();
		csr_write(tmu_pkg::csr_adr_t'(`TMU_CSR_CTRL), {30'd0, cfg_ken, 1'b0});
		csr_write(tmu_pkg::csr_adr_t'(`TMU_CSR_BRIGHT), {26'd0, cfg_bright});
		csr_write(tmu_pkg::csr_adr_t'(`TMU_CSR_CKEY), {16'd0, cfg_key});
		csr_write(tmu_pkg::csr_adr_t'(`TMU_CSR_DFBUF), {7'd0, cfg_fbuf});
		csr_write(tmu_pkg::csr_adr_t'(`TMU_CSR_DHRES), {21'd0, cfg_hres});
		csr_write(tmu_pkg::csr_adr_t'(`TMU_CSR_DVRES), {21'd0, cfg_vres});
		csr_write(tmu_pkg::csr_adr_t'(`TMU_CSR_HOFF), {20'd0, cfg_hoff});
		csr_write(tmu_pkg::csr_adr_t'(`TMU_CSR_VOFF), {20'd0, cfg_voff});
		csr_write(tmu_pkg::csr_adr_t'(`TMU_CSR_CTRL), {30'd0, cfg_ken, 1'b1}); // start
	endtask

	task automatic send_point(input tmu_pkg::coord_t x, input tmu_pkg::coord_t y,
		input tmu_pkg::pixel_t c, input bit last);
		tmu_pkg::dadr_t adr;
		tmu_pkg::pixel_t col;
		@(negedge sys_clk);
		if (ref_point(x, y, c, cfg_hoff, cfg_voff, cfg_hres, cfg_vres, cfg_fbuf,
			cfg_bright, cfg_ken, cfg_key, adr, col))
			model_pixel(adr, col);
		pt_stb_i = 1'b1;
		pt_x_i = x;
		pt_y_i = y;
		pt_color_i = c;
		pt_last_i = last;
		do
			@(posedge sys_clk);
		while (!pt_ack_o);
	endtask

	task automatic finish_frame();
		@(negedge sys_clk);
		pt_stb_i = 1'b0;
		pt_last_i = 1'b0;
		if (m_sel != '0)
			push_open(); // flush of the partial burst
		frames++;
		while (irq_cnt < frames)
			@(negedge sys_clk);
		repeat (4) @(negedge sys_clk);
		check_count("irq pulses", frames, irq_cnt);
		check_count("bursts", model_cnt, seen_cnt);
		check_csr(tmu_pkg::csr_adr_t'(`TMU_CSR_CTRL), {30'd0, cfg_ken, 1'b0});
	endtask

	always @(negedge sys_clk)
		burst_ack_i = stall_on ? (($random(seed) & 3) != 0) : 1'b1;

	always @(negedge sys_clk) begin
		if (irq_o)
			irq_cnt++;
		if (dut0.assert0.hold_bad || dut0.assert0.sel_bad || dut0.assert0.irq_bad)
			abort_run("a bound assertion on the burst or irq ports failed");
	end

	always @(posedge sys_clk) begin
		cycles++;
		if (cycles >= LIMIT)
			abort_run("timeout: the run did not finish within the cycle limit");
	end

	always @(posedge sys_clk) begin
		if (!sys_rst && burst_stb_o && burst_ack_i) begin
			if (exp_adr_q.size() == 0)
				abort_run("a burst was transferred while none was expected");
			else begin
				check_burst(exp_adr_q.pop_front(), exp_sel_q.pop_front(), exp_dat_q.pop_front());
				seen_cnt++;
			end
		end
	end

	initial begin
		logic [31:0] vals [8];
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		csr_a_i = '0;
		csr_we_i = 1'b0;
		csr_di_i = 32'd0;
		pt_stb_i = 1'b0;
		pt_x_i = '0;
		pt_y_i = '0;
		pt_color_i = '0;
		pt_last_i = 1'b0;
		burst_ack_i = 1'b1;
		m_sel = '0;
		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		vals = '{32'h2, 32'h2a, 32'hbeef, 32'h1abcdef, 32'h7ff, 32'h155, 32'hffd, 32'h800};
		check_csr(tmu_pkg::csr_adr_t'(`TMU_CSR_CTRL), 32'd0);
		for (int i = 0; i < 8; i++) begin
			csr_write(tmu_pkg::csr_adr_t'(i), vals[i]);
			check_csr(tmu_pkg::csr_adr_t'(i), vals[i]);
		end

		// full brightness, rows and columns on every side of the screen clipped
		cfg_bright = 6'd63;
		cfg_ken = 1'b0;
		cfg_key = 16'h0;
		cfg_fbuf = 25'h1001;
		cfg_hres = 11'd12;
		cfg_vres = 11'd2;
		cfg_hoff = 12'sd3;
		cfg_voff = 12'sd2;
		write_config();
		for (int i = 0; i < N_A; i++)
			send_point(tmu_pkg::coord_t'(i % 16 - 4), tmu_pkg::coord_t'(i / 16 - 3),
				tmu_pkg::pixel_t'($random(seed)), i == N_A - 1);
		finish_frame();

		// dimmed, with the chroma key on every fourth point
		cfg_bright = 6'd20;
		cfg_ken = 1'b1;
		cfg_key = 16'hf81f;
		cfg_fbuf = 25'h40;
		cfg_hres = 11'd20;
		cfg_vres = 11'd10;
		cfg_hoff = -12'sd4;
		cfg_voff = 12'sd1;
		write_config();
		for (int i = 0; i < N_B; i++)
			send_point(tmu_pkg::coord_t'(i % 20 + 4), tmu_pkg::coord_t'(i / 20),
				(i % 4 == 1) ? cfg_key : tmu_pkg::pixel_t'($random(seed)), i == N_B - 1);
		finish_frame();

		// random points under random output stalls, addresses wrap at the top
		stall_on = 1'b1;
		cfg_bright = 6'd45;
		cfg_key = 16'h0;
		cfg_fbuf = 25'h1fffff0;
		cfg_hres = 11'd24;
		cfg_hoff = 12'sd0;
		cfg_voff = 12'sd0;
		write_config();
		for (int i = 0; i < N_C; i++)
			send_point(tmu_pkg::coord_t'(($random(seed) & 31) - 4),
				tmu_pkg::coord_t'(($random(seed) & 15) - 2),
				(i % 8 == 3) ? 16'h0 : tmu_pkg::pixel_t'($random(seed)), i == N_C - 1);
		finish_frame();

		$display("Regression passed");
		$finish;
	end

endmodule

// ==== tmu_assert.sv ====
/* burst and interrupt port checker
   bound into the top level, flags stay set once a property fails */
`timescale 1ns/1ns

module tmu_assert (
	input logic sys_clk,
	input logic sys_rst,
	input logic burst_stb_i,
	input logic burst_ack_i,
	input tmu_pkg::burst_adr_t burst_adr_i,
	input tmu_pkg::burst_sel_t burst_sel_i,
	input tmu_pkg::burst_data_t burst_dat_i,
	input logic irq_i
);

	logic hold_bad = 1'b0; // sticky failure flags
	logic sel_bad = 1'b0;
	logic irq_bad = 1'b0;

	hold_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		burst_stb_i && !burst_ack_i |=> burst_stb_i && burst_adr_i === $past(burst_adr_i)
		&& burst_sel_i === $past(burst_sel_i) && burst_dat_i === $past(burst_dat_i))
	else begin
		hold_bad = 1'b1;
		$error("burst output changed while stalled");
	end

	sel_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		burst_stb_i |-> burst_sel_i != '0)
	else begin
		sel_bad = 1'b1;
		$error("burst strobe with empty byte selects");
	end

	irq_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq_i |=> !irq_i)
	else begin
		irq_bad = 1'b1;
		$error("irq high for two cycles");
	end

endmodule

// ==== tmu_burst.sv ====
/* burst assembler
   packs pixels into 4-pixel 64-bit write bursts, flushes the open one on request */
`timescale 1ns/1ns
`include "tmu_consts.svh"

module tmu_burst (
	input logic sys_clk,
	input logic sys_rst,
	input logic flush_i,
	input logic pipe_stb_i,
	input tmu_pkg::dadr_t adr_i,
	input tmu_pkg::pixel_t color_i,
	output logic pipe_ack_o,
	output logic busy_o,
	output logic burst_stb_o,
	output tmu_pkg::burst_adr_t burst_adr_o,
	output tmu_pkg::burst_sel_t burst_sel_o,
	output tmu_pkg::burst_data_t burst_dat_o,
	input logic burst_ack_i
);

	tmu_pkg::burst_adr_t open_adr;
	tmu_pkg::burst_sel_t open_sel;
	tmu_pkg::burst_data_t open_dat;

	tmu_pkg::burst_adr_t in_badr;
	logic [1:0] slot; // pixel index within the burst
	tmu_pkg::burst_sel_t slot_sel;
	logic open_any;
	logic same;
	logic out_free;
	logic in_xfer;
	logic in_move;
	logic flush_move;
	logic move;

	assign in_badr = adr_i[$bits(adr_i)-1:2];
	assign slot = adr_i[1:0];
	assign slot_sel = tmu_pkg::burst_sel_t'(2'b11) << {slot, 1'b0};

	assign open_any = |open_sel;
	assign same = !open_any || (in_badr == open_adr);
	assign out_free = !burst_stb_o || burst_ack_i; // output register empty after this edge

	// a pixel for another burst waits until the output register can take the open one
	assign pipe_ack_o = same || out_free;
	assign in_xfer = pipe_stb_i && pipe_ack_o;
	assign in_move = in_xfer && !same;
	assign flush_move = flush_i && open_any && out_free;
	assign move = in_move || flush_move;

	// the controller only flushes with the pipeline drained, so only the output can hold work
	assign busy_o = burst_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			open_sel <= '0;
		else if (in_xfer) begin
			if (same)
				open_sel <= open_sel | slot_sel;
			else
				open_sel <= slot_sel; // fresh burst
		end else if (flush_move)
			open_sel <= '0;
	end

	always_ff @(posedge sys_clk) begin
		if (in_xfer) begin
			open_adr <= in_badr;
			open_dat[`TMU_PIXEL_W*slot +: `TMU_PIXEL_W] <= color_i; // later pixel overwrites
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			burst_stb_o <= 1'b0;
		else if (move)
			burst_stb_o <= 1'b1;
		else if (burst_ack_i)
			burst_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (move) begin
			burst_adr_o <= open_adr;
			burst_sel_o <= open_sel;
			burst_dat_o <= open_dat;
		end
	end

endmodule

// ==== tmu_clip.sv ====
/* offset and clip stage
   applies destination offsets, drops off-screen points, forms word address */
`timescale 1ns/1ns
`include "tmu_consts.svh"

module tmu_clip (
	input logic sys_clk,
	input logic sys_rst,
	input logic run_i,
	input logic pipe_stb_i,
	input tmu_pkg::coord_t x_i,
	input tmu_pkg::coord_t y_i,
	input tmu_pkg::pixel_t color_i,
	output logic pipe_ack_o,
	input tmu_pkg::coord_t hoff_i,
	input tmu_pkg::coord_t voff_i,
	input tmu_pkg::res_t hres_i,
	input tmu_pkg::res_t vres_i,
	input tmu_pkg::dadr_t fbuf_i,
	output logic pipe_stb_o,
	output tmu_pkg::dadr_t adr_o,
	output tmu_pkg::pixel_t color_o,
	output logic busy_o,
	input logic pipe_ack_i
);

	tmu_pkg::coord_t fx, fy;
	tmu_pkg::res_t ux, uy;
	tmu_pkg::dadr_t row_base;
	tmu_pkg::dadr_t adr_next;
	logic keep;
	logic in_xfer;

	assign fx = x_i + hoff_i; // wraps at coordinate width
	assign fy = y_i + voff_i;
	assign ux = fx[`TMU_RES_W-1:0];
	assign uy = fy[`TMU_RES_W-1:0];

	// sign bit clear and below the resolution
	assign keep = !fx[`TMU_COORD_W-1] && (ux < hres_i)
		&& !fy[`TMU_COORD_W-1] && (uy < vres_i);

	assign row_base = tmu_pkg::dadr_t'(uy) * tmu_pkg::dadr_t'(hres_i);
	assign adr_next = fbuf_i + row_base + tmu_pkg::dadr_t'(ux);

	assign pipe_ack_o = run_i && (!pipe_stb_o || pipe_ack_i);
	assign in_xfer = pipe_stb_i && pipe_ack_o;
	assign busy_o = pipe_stb_o; // item held in the register

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (in_xfer)
			pipe_stb_o <= keep; // clipped points vanish here
		else if (pipe_ack_i)
			pipe_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (in_xfer) begin
			adr_o <= adr_next;
			color_o <= color_i;
		end
	end

endmodule

// ==== tmu_consts.svh ====
/* texture mapping pixel back end
   widths, burst geometry and CSR word indices */
`ifndef TMU_CONSTS_SVH
`define TMU_CONSTS_SVH

`define TMU_FML_DEPTH 26 // memory byte address bits
`define TMU_COORD_W 12 // signed coordinate
`define TMU_RES_W 11 // screen resolution
`define TMU_PIXEL_W 16 // rgb565
`define TMU_BURST_PIXELS 4 // pixels per write burst
`define TMU_BRIGHT_W 6 // brightness 0..63
`define TMU_CSR_ADR_W 4 // csr word index

`define TMU_CSR_CTRL 0 // bit 0 start/busy, bit 1 chroma key enable
`define TMU_CSR_BRIGHT 1
`define TMU_CSR_CKEY 2
`define TMU_CSR_DFBUF 3
`define TMU_CSR_DHRES 4
`define TMU_CSR_DVRES 5
`define TMU_CSR_HOFF 6
`define TMU_CSR_VOFF 7

`endif

// ==== tmu_ctlif.sv ====
/* texture mapping controller
   CSR bank, frame FSM, burst flush request and end-of-frame interrupt */
`timescale 1ns/1ns
`include "tmu_consts.svh"

module tmu_ctlif (
	input logic sys_clk,
	input logic sys_rst,
	input tmu_pkg::csr_adr_t csr_a_i,
	input logic csr_we_i,
	input logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,
	output logic irq_o,
	input logic pt_xfer_i,
	input logic pt_last_i,
	input logic pipe_busy_i,
	output logic run_o,
	output logic flush_o,
	output tmu_pkg::bright_t bright_o,
	output logic ckey_en_o,
	output tmu_pkg::pixel_t ckey_o,
	output tmu_pkg::dadr_t dst_fbuf_o,
	output tmu_pkg::res_t dst_hres_o,
	output tmu_pkg::res_t dst_vres_o,
	output tmu_pkg::coord_t hoff_o,
	output tmu_pkg::coord_t voff_o
);

	tmu_pkg::ctl_state_t state, next_state;
	logic start;
	logic busy;
	logic [31:0] rd_val;

	assign start = csr_we_i && (csr_a_i == `TMU_CSR_ADR_W'(`TMU_CSR_CTRL)) && csr_di_i[0];
	assign busy = (state != tmu_pkg::IDLE);
	assign run_o = (state == tmu_pkg::WAIT_LAST); // gates the input ack
	assign flush_o = (state == tmu_pkg::FLUSH);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			ckey_en_o <= 1'b0;
			bright_o <= '0;
			ckey_o <= '0;
			dst_fbuf_o <= '0;
			dst_hres_o <= '0;
			dst_vres_o <= '0;
			hoff_o <= '0;
			voff_o <= '0;
		end else if (csr_we_i) begin
			case (csr_a_i)
				`TMU_CSR_ADR_W'(`TMU_CSR_CTRL): ckey_en_o <= csr_di_i[1];
				`TMU_CSR_ADR_W'(`TMU_CSR_BRIGHT): bright_o <= csr_di_i[`TMU_BRIGHT_W-1:0];
				`TMU_CSR_ADR_W'(`TMU_CSR_CKEY): ckey_o <= csr_di_i[`TMU_PIXEL_W-1:0];
				`TMU_CSR_ADR_W'(`TMU_CSR_DFBUF): dst_fbuf_o <= csr_di_i[`TMU_FML_DEPTH-2:0];
				`TMU_CSR_ADR_W'(`TMU_CSR_DHRES): dst_hres_o <= csr_di_i[`TMU_RES_W-1:0];
				`TMU_CSR_ADR_W'(`TMU_CSR_DVRES): dst_vres_o <= csr_di_i[`TMU_RES_W-1:0];
				`TMU_CSR_ADR_W'(`TMU_CSR_HOFF): hoff_o <= csr_di_i[`TMU_COORD_W-1:0];
				`TMU_CSR_ADR_W'(`TMU_CSR_VOFF): voff_o <= csr_di_i[`TMU_COORD_W-1:0];
				default: ;
			endcase
		end
	end

	always_comb begin
		case (csr_a_i)
			`TMU_CSR_ADR_W'(`TMU_CSR_CTRL): rd_val = {30'd0, ckey_en_o, busy};
			`TMU_CSR_ADR_W'(`TMU_CSR_BRIGHT): rd_val = 32'(bright_o);
			`TMU_CSR_ADR_W'(`TMU_CSR_CKEY): rd_val = 32'(ckey_o);
			`TMU_CSR_ADR_W'(`TMU_CSR_DFBUF): rd_val = 32'(dst_fbuf_o);
			`TMU_CSR_ADR_W'(`TMU_CSR_DHRES): rd_val = 32'(dst_hres_o);
			`TMU_CSR_ADR_W'(`TMU_CSR_DVRES): rd_val = 32'(dst_vres_o);
			`TMU_CSR_ADR_W'(`TMU_CSR_HOFF): rd_val = 32'($unsigned(hoff_o));
			`TMU_CSR_ADR_W'(`TMU_CSR_VOFF): rd_val = 32'($unsigned(voff_o));
			default: rd_val = 32'd0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do_o <= 32'd0;
			state <= tmu_pkg::IDLE;
			irq_o <= 1'b0;
		end else begin
			csr_do_o <= rd_val; // one cycle read latency
			state <= next_state;
			irq_o <= (state == tmu_pkg::WAIT_FLUSH) && !pipe_busy_i; // first idle cycle
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			tmu_pkg::IDLE: if (start) next_state = tmu_pkg::WAIT_LAST;
			tmu_pkg::WAIT_LAST: if (pt_xfer_i && pt_last_i) next_state = tmu_pkg::WAIT_PROCESS;
			tmu_pkg::WAIT_PROCESS: if (!pipe_busy_i) next_state = tmu_pkg::FLUSH;
			tmu_pkg::FLUSH: next_state = tmu_pkg::WAIT_FLUSH; // single flush pulse
			tmu_pkg::WAIT_FLUSH: if (!pipe_busy_i) next_state = tmu_pkg::IDLE;
			default: next_state = tmu_pkg::IDLE;
		endcase
	end

endmodule

// ==== tmu_decay.sv ====
/* decay stage
   per-channel brightness scaling and chroma key drop */
`timescale 1ns/1ns

module tmu_decay (
	input logic sys_clk,
	input logic sys_rst,
	input tmu_pkg::bright_t bright_i,
	input logic ckey_en_i,
	input tmu_pkg::pixel_t ckey_i,
	input logic pipe_stb_i,
	input tmu_pkg::dadr_t adr_i,
	input tmu_pkg::pixel_t color_i,
	output logic pipe_ack_o,
	output logic pipe_stb_o,
	output tmu_pkg::dadr_t adr_o,
	output tmu_pkg::pixel_t color_o,
	output logic busy_o,
	input logic pipe_ack_i
);

	logic [6:0] bmul; // brightness + 1, up to 64
	logic [11:0] r_prod;
	logic [12:0] g_prod;
	logic [11:0] b_prod;
	tmu_pkg::pixel_t scaled;
	logic keep;
	logic in_xfer;

	assign bmul = {1'b0, bright_i} + 7'd1;
	assign r_prod = color_i[15:11] * bmul;
	assign g_prod = color_i[10:5] * bmul;
	assign b_prod = color_i[4:0] * bmul;
	assign scaled = {r_prod[10:6], g_prod[11:6], b_prod[10:6]}; // >> 6 per field

	assign keep = !(ckey_en_i && (color_i == ckey_i));

	assign pipe_ack_o = !pipe_stb_o || pipe_ack_i;
	assign in_xfer = pipe_stb_i && pipe_ack_o;
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (in_xfer)
			pipe_stb_o <= keep; // keyed pixels dropped
		else if (pipe_ack_i)
			pipe_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (in_xfer) begin
			adr_o <= adr_i;
			color_o <= scaled;
		end
	end

endmodule

// ==== tmu_pkg.sv ====
/* texture mapping pixel back end
   shared vector types and controller states */
package tmu_pkg;

`include "tmu_consts.svh"

	typedef logic signed [`TMU_COORD_W-1:0] coord_t; // destination coordinate or offset
	typedef logic [`TMU_RES_W-1:0] res_t;
	typedef logic [`TMU_PIXEL_W-1:0] pixel_t; // rgb565
	typedef logic [`TMU_BRIGHT_W-1:0] bright_t;
	typedef logic [`TMU_FML_DEPTH-2:0] dadr_t; // 16-bit word address
	typedef logic [`TMU_FML_DEPTH-4:0] burst_adr_t; // word address / 4
	typedef logic [2*`TMU_BURST_PIXELS-1:0] burst_sel_t; // byte selects
	typedef logic [`TMU_PIXEL_W*`TMU_BURST_PIXELS-1:0] burst_data_t;
	typedef logic [`TMU_CSR_ADR_W-1:0] csr_adr_t;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_LAST, // accepting points
		WAIT_PROCESS, // last point in, pipeline draining
		FLUSH,
		WAIT_FLUSH
	} ctl_state_t;

endpackage

// ==== tmu_top.sv ====
/* texture mapping pixel back end top
   controller plus clip, decay and burst stages on a stb/ack chain */
`timescale 1ns/1ns

module tmu_top (
	input logic sys_clk,
	input logic sys_rst,
	input tmu_pkg::csr_adr_t csr_a_i,
	input logic csr_we_i,
	input logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,
	output logic irq_o,
	input logic pt_stb_i,
	output logic pt_ack_o,
	input tmu_pkg::coord_t pt_x_i,
	input tmu_pkg::coord_t pt_y_i,
	input tmu_pkg::pixel_t pt_color_i,
	input logic pt_last_i,
	output logic burst_stb_o,
	input logic burst_ack_i,
	output tmu_pkg::burst_adr_t burst_adr_o,
	output tmu_pkg::burst_sel_t burst_sel_o,
	output tmu_pkg::burst_data_t burst_dat_o
);

	logic pt_xfer, pipe_busy, run, flush, ckey_en;
	tmu_pkg::bright_t bright;
	tmu_pkg::pixel_t ckey;
	tmu_pkg::dadr_t dst_fbuf;
	tmu_pkg::res_t dst_hres, dst_vres;
	tmu_pkg::coord_t hoff, voff;
	logic clip_stb, clip_ack, clip_busy;
	tmu_pkg::dadr_t clip_adr;
	tmu_pkg::pixel_t clip_color;
	logic decay_stb, decay_ack, decay_busy;
	tmu_pkg::dadr_t decay_adr;
	tmu_pkg::pixel_t decay_color;
	logic burst_busy;

	assign pt_xfer = pt_stb_i && pt_ack_o;
	assign pipe_busy = clip_busy || decay_busy || burst_busy;

	tmu_ctlif ctlif0 (
		.sys_clk, .sys_rst, .csr_a_i, .csr_we_i, .csr_di_i, .csr_do_o, .irq_o,
		.pt_xfer_i(pt_xfer), .pt_last_i, .pipe_busy_i(pipe_busy),
		.run_o(run), .flush_o(flush), .bright_o(bright), .ckey_en_o(ckey_en),
		.ckey_o(ckey), .dst_fbuf_o(dst_fbuf), .dst_hres_o(dst_hres),
		.dst_vres_o(dst_vres), .hoff_o(hoff), .voff_o(voff)
	);

	tmu_clip clip0 (
		.sys_clk, .sys_rst, .run_i(run),
		.pipe_stb_i(pt_stb_i), .x_i(pt_x_i), .y_i(pt_y_i), .color_i(pt_color_i),
		.pipe_ack_o(pt_ack_o), .hoff_i(hoff), .voff_i(voff),
		.hres_i(dst_hres), .vres_i(dst_vres), .fbuf_i(dst_fbuf),
		.pipe_stb_o(clip_stb), .adr_o(clip_adr), .color_o(clip_color),
		.busy_o(clip_busy), .pipe_ack_i(clip_ack)
	);

	tmu_decay decay0 (
		.sys_clk, .sys_rst, .bright_i(bright), .ckey_en_i(ckey_en), .ckey_i(ckey),
		.pipe_stb_i(clip_stb), .adr_i(clip_adr), .color_i(clip_color),
		.pipe_ack_o(clip_ack), .pipe_stb_o(decay_stb), .adr_o(decay_adr),
		.color_o(decay_color), .busy_o(decay_busy), .pipe_ack_i(decay_ack)
	);

	tmu_burst burst0 (
		.sys_clk, .sys_rst, .flush_i(flush),
		.pipe_stb_i(decay_stb), .adr_i(decay_adr), .color_i(decay_color),
		.pipe_ack_o(decay_ack), .busy_o(burst_busy),
		.burst_stb_o, .burst_adr_o, .burst_sel_o, .burst_dat_o, .burst_ack_i
	);

endmodule
